//--- all.f
logic/zxmem_pkg.sv
logic/paging_regs.sv
logic/divmmc_mapper.sv
logic/sram_addr_mux.sv
logic/zxmem_top.sv
testbench/zxmem_tb.sv

//--- testbench/zxmem_tb.sv
`timescale 1ns/10ps

module zxmem_tb
   import zxmem_pkg::*;
();

   localparam logic [7:0] DIVMMC_PORT   = 8'hE3;
   localparam logic [4:0] ROM_PAGE_BASE = 5'd8;
   localparam int N_RAND    = 4;             // random accesses per step
   localparam int CYC_RESET = 3;
   localparam int CYC_TOTAL = 5 * CYC_RESET + 4 * N_RAND * 2 + (N_RAND * 4 + 8) + 4 * 5
                              + (N_RAND * 3 + 7) + 7 * 6;

   // deferred entry points with index 0 rightmost
   localparam logic [5:0][15:0] ENTRY_POINTS = {16'h0562, 16'h04C6, 16'h0066,
                                               16'h0038, 16'h0008, 16'h0000};

   logic       clk;
   logic       mrst_n;
   cpu_bus_t   bus;
   sram_addr_u sram_addr;
   logic       sram_we_n;

   // reference state that follows the register rules
   logic [2:0]  m_bank;
   logic        m_rom_lo;
   logic        m_locked;
   logic [2:0]  m_1ffd;      // allram in bit 0 and arrangement in bits 2..1
   logic        m_conmem;
   logic        m_mapram;
   logic [3:0]  m_page;
   logic        m_pending;
   logic        m_paged;
   logic [31:0] rng;
   int          err_count;
   int          tests_ok;
   int          tests_bad;

   zxmem_top #(
      .DIVMMC_PORT   (DIVMMC_PORT),
      .ROM_PAGE_BASE (ROM_PAGE_BASE)
   ) zxmem_top_i (
      .clk       (clk),
      .mrst_n    (mrst_n),
      .bus       (bus),
      .sram_addr (sram_addr),
      .sram_we_n (sram_we_n)
   );

   always #2 clk = ~clk;                     // 4 ns period

   // watchdog at twice the length of all bus cycles
   initial begin
      #(CYC_TOTAL * 4 * 2);
      $display("timeout: the run did not finish within %0d ns", CYC_TOTAL * 8);
      $display("Test failed");
      $finish;
   end

   // --------------------------------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // random address inside base where only mask bits vary
   function automatic logic [15:0] rand_addr(input logic [15:0] base, input logic [15:0] mask);
      logic [31:0] r;
      r = next_rand();
      return base | (r[15:0] & mask);
   endfunction

   // strobes as {mreq_n, iorq_n, rd_n, wr_n, m1_n}
   function automatic cpu_bus_t make_bus(input logic [15:0] a, input logic [7:0] din,
                                         input logic [4:0] strobes);
      cpu_bus_t b;
      b = {a, din, strobes};                 // field order of cpu_bus_t
      return b;
   endfunction

   // --------------------------------------------------------------------------
   // reference model
   // --------------------------------------------------------------------------
   function automatic sram_addr_u ref_addr(input cpu_bus_t b);
      sram_addr_u r;
      logic [4:0] p16;
      logic [5:0] p8;
      logic       use8;
      r    = '0;
      p16  = 5'd0;
      p8   = 6'd0;
      use8 = 1'b0;
      if (!b.mreq_n) begin
         case (b.a[15:14])
            2'b00: begin
               if (m_conmem || m_paged) begin
                  use8 = 1'b1;
                  if (!b.a[13])
                     p8 = (m_mapram && !m_conmem) ? DIVMMC_MAPRAM_PAGE8 : DIVMMC_ROM_PAGE8;
                  else
                     p8 = DIVMMC_RAM_BASE8 + {2'b00, m_page};
               end
               else if (!m_1ffd[0])
                  p16 = ROM_PAGE_BASE + {3'b000, m_1ffd[2], m_rom_lo};
               else
                  p16 = (m_1ffd[2:1] == 2'd0) ? 5'd0 : 5'd4;
            end
            2'b01: begin
               if (!m_1ffd[0])         p16 = SCREEN_PAGE;
               else if (m_1ffd[2:1] == 2'd0) p16 = 5'd1;
               else if (m_1ffd[2:1] == 2'd3) p16 = 5'd7;
               else                    p16 = 5'd5;
            end
            2'b10: p16 = (m_1ffd[0] && m_1ffd[2:1] != 2'd0) ? 5'd6 : 5'd2;
            default: begin
               if (!m_1ffd[0]) p16 = {2'b00, m_bank};
               else            p16 = (m_1ffd[2:1] == 2'd1) ? 5'd7 : 5'd3;
            end
         endcase
         if (use8) begin
            r.v8.page8 = p8;
            r.v8.off13 = b.a[12:0];
         end
         else begin
            r.v16.page16 = p16;
            r.v16.off14  = b.a[13:0];
         end
      end
      return r;
   endfunction

   function automatic logic ref_we(input cpu_bus_t b);
      logic prot;
      prot = 1'b0;
      if (b.a[15:14] == 2'b00) begin       // only region 0 is ever protected
         if (m_conmem || m_paged)
            prot = !b.a[13] || (m_mapram && !m_conmem && m_page == 4'd3);
         else
            prot = !m_1ffd[0];
      end
      return b.mreq_n | b.wr_n | prot;
   endfunction

   // state after the edge that closes cycle b
   task automatic advance_model(input cpu_bus_t b);
      logic fetch;
      logic old_pending;
      int   i;
      if (!b.iorq_n && !b.wr_n) begin
         if (!m_locked && b.a[0] && !b.a[1]) begin
            if (b.a[15:12] == 4'b0001)
               m_1ffd = b.din[2:0];
            else if (b.a[15:14] == 2'b01) begin
               m_bank   = b.din[2:0];
               m_rom_lo = b.din[4];
               m_locked = b.din[5];
            end
         end
         if (b.a[7:0] == DIVMMC_PORT) begin  // lock does not cover divmmc
            m_conmem = b.din[7];
            m_mapram = b.din[6];
            m_page   = b.din[3:0];
         end
      end
      old_pending = m_pending;
      fetch = !b.mreq_n && !b.rd_n && !b.m1_n;
      if (fetch) begin
         for (i = 0; i < 6; i++)
            if (b.a == ENTRY_POINTS[i]) m_pending = 1'b1;
         if (b.a[15:8] == 8'h3D) begin    // immediate
            m_pending = 1'b1;
            m_paged   = 1'b1;
         end
         if (b.a >= 16'h1FF8 && b.a <= 16'h1FFF) m_pending = 1'b0;
      end
      if (b.m1_n) m_paged = old_pending;
   endtask

   // --------------------------------------------------------------------------
   // compare tasks and bus cycles
   // --------------------------------------------------------------------------
   task automatic check_addr(input sram_addr_u got, input sram_addr_u exp, input string what);
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0d ns: %s, sram_addr %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_we(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0d ns: %s, sram_we_n %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic run_cycle(input cpu_bus_t b, input string what);
      @(posedge clk);
      bus <= b;
      @(negedge clk);                        // mux settled mid cycle
      check_addr(sram_addr, ref_addr(b), what);
      check_we(sram_we_n, ref_we(b), what);
      advance_model(b);
   endtask

   task automatic io_write(input logic [15:0] a, input logic [7:0] d);
      run_cycle(make_bus(a, d, 5'b10101), $sformatf("io write %h <= %h", a, d));
   endtask

   task automatic mem_access(input logic [15:0] a, input logic wr);
      logic [31:0] r;
      r = next_rand();
      if (wr) run_cycle(make_bus(a, r[7:0], 5'b01101), $sformatf("write %h", a));
      else    run_cycle(make_bus(a, r[7:0], 5'b01011), $sformatf("read %h", a));
   endtask

   task automatic m1_fetch(input logic [15:0] a);
      run_cycle(make_bus(a, 8'h00, 5'b01010), $sformatf("m1 fetch %h", a));
   endtask

   task automatic do_reset();
      @(posedge clk);
      mrst_n <= 1'b0;
      bus    <= make_bus(16'h0000, 8'h00, 5'b11111);
      repeat (2) @(posedge clk);
      mrst_n <= 1'b1;
      {m_bank, m_rom_lo, m_locked, m_1ffd} = '0;
      {m_conmem, m_mapram, m_page, m_pending, m_paged} = '0;
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         tests_ok++;
         $display("%-16s ok", name);
      end
      else begin
         tests_bad++;
         $display("%-16s %0d mismatches", name, err_count - errs_before);
      end
   endtask

   // --------------------------------------------------------------------------
   // directed tests
   // --------------------------------------------------------------------------
   task automatic test_reset_map();
      int e0;
      int r;
      e0 = err_count;
      do_reset();
      for (r = 0; r < 4; r++)
         repeat (N_RAND) begin
            mem_access(rand_addr({r[1:0], 14'h0000}, 16'h3FFF), 1'b0);
            mem_access(rand_addr({r[1:0], 14'h0000}, 16'h3FFF), 1'b1);
         end
      report_test("reset_map", e0);
   endtask

   task automatic test_port_7ffd();
      int          e0;
      logic [31:0] d;
      e0 = err_count;
      do_reset();
      repeat (N_RAND) begin
         d = next_rand();
         io_write(16'h7FFD, d[7:0] & 8'hDF);   // lock bit clear
         mem_access(rand_addr(16'hC000, 16'h3FFF), 1'b1);
         mem_access(rand_addr(16'hC000, 16'h3FFF), 1'b0);
         mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
      end
      d = next_rand();
      io_write(16'h7FFD, d[7:0] | 8'h20);
      mem_access(rand_addr(16'hC000, 16'h3FFF), 1'b0);
      mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
      d = next_rand();
      io_write(16'h7FFD, d[7:0]);              // ignored from here on
      io_write(16'h1FFD, 8'h07);
      mem_access(rand_addr(16'hC000, 16'h3FFF), 1'b0);
      mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b1);
      mem_access(rand_addr(16'h4000, 16'h3FFF), 1'b0);
      report_test("port_7ffd", e0);
   endtask

   task automatic test_allram();
      int e0;
      int arr;
      int r;
      e0 = err_count;
      do_reset();
      for (arr = 0; arr < 4; arr++) begin
         io_write(16'h1FFD, {5'b00000, arr[1:0], 1'b1});
         for (r = 0; r < 4; r++)
            mem_access(rand_addr({r[1:0], 14'h0000}, 16'h3FFF), 1'b1);
      end
      report_test("allram", e0);
   endtask

   task automatic test_divmmc_port();
      int          e0;
      logic [31:0] d;
      e0 = err_count;
      do_reset();
      repeat (N_RAND) begin
         d = next_rand();
         io_write({8'h00, DIVMMC_PORT}, {4'b1000, d[3:0]});  // conmem
         mem_access(rand_addr(16'h0000, 16'h1FFF), 1'b1);
         mem_access(rand_addr(16'h2000, 16'h1FFF), 1'b1);
      end
      io_write({8'h00, DIVMMC_PORT}, 8'h43);   // mapram with page 3
      m1_fetch(16'h3D00);                      // map in without conmem
      mem_access(rand_addr(16'h0000, 16'h1FFF), 1'b1);
      mem_access(rand_addr(16'h2000, 16'h1FFF), 1'b1);
      io_write({8'h00, DIVMMC_PORT}, 8'h45);
      mem_access(rand_addr(16'h2000, 16'h1FFF), 1'b1);
      mem_access(rand_addr(16'h0000, 16'h1FFF), 1'b0);
      report_test("divmmc_port", e0);
   endtask

   task automatic test_automap();
      int e0;
      int i;
      e0 = err_count;
      do_reset();
      for (i = 0; i < 6; i++) begin
         m1_fetch(ENTRY_POINTS[i]);            // still unmapped here
         mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
         mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b1);
         m1_fetch(rand_addr(16'h1FF8, 16'h0007));
         mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
         mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
      end
      m1_fetch(rand_addr(16'h3D00, 16'h00FF));
      mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
      mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b1);
      m1_fetch(16'h1FF8);
      mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
      mem_access(rand_addr(16'h0000, 16'h3FFF), 1'b0);
      report_test("automap", e0);
   endtask

   initial begin
      clk       = 1'b0;
      mrst_n    = 1'b0;
      bus       = make_bus(16'h0000, 8'h00, 5'b11111);   // idle bus
      rng       = 32'hae3fc8c3;
      err_count = 0;
      tests_ok  = 0;
      tests_bad = 0;
      test_reset_map();
      test_port_7ffd();
      test_allram();
      test_divmmc_port();
      test_automap();
      $display("tests ok %0d, tests with mismatches %0d, mismatches %0d",
               tests_ok, tests_bad, err_count);
      if (err_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- logic/zxmem_top.sv
`timescale 1ns/10ps

module zxmem_top
   import zxmem_pkg::*;
#(
   parameter logic [7:0] DIVMMC_PORT   = 8'hE3,  // divmmc control port
   parameter logic [4:0] ROM_PAGE_BASE = 5'd8    // first 16K rom page in sram
)(
   input  logic       clk,
   input  logic       mrst_n,
   input  cpu_bus_t   bus,
   output sram_addr_u sram_addr,
   output logic       sram_we_n
);

   paging_t paging;    // 7ffd/1ffd state
   divmmc_t divmmc;    // divmmc control and automap state

   // -------------------------------------------------------------------------
   // registered state, one cycle after the io write
   // -------------------------------------------------------------------------
   paging_regs paging_regs_i (
      .clk    (clk),
      .mrst_n (mrst_n),
      .bus    (bus),
      .paging (paging)
   );

   divmmc_mapper #(
      .DIVMMC_PORT (DIVMMC_PORT)
   ) divmmc_mapper_i (
      .clk    (clk),
      .mrst_n (mrst_n),
      .bus    (bus),
      .divmmc (divmmc)
   );

   // address translation, same cycle
   sram_addr_mux #(
      .ROM_PAGE_BASE (ROM_PAGE_BASE)
   ) sram_addr_mux_i (
      .bus       (bus),
      .paging    (paging),
      .divmmc    (divmmc),
      .sram_addr (sram_addr),
      .sram_we_n (sram_we_n)
   );

endmodule

//--- logic/sram_addr_mux.sv
`timescale 1ns/10ps

module sram_addr_mux
   import zxmem_pkg::*;
#(
   parameter logic [4:0] ROM_PAGE_BASE = 5'd8
)(
   input  cpu_bus_t   bus,
   input  paging_t    paging,
   input  divmmc_t    divmmc,
   output sram_addr_u sram_addr,
   output logic       sram_we_n
);

   logic protect;      // write protect for this access

   always_comb begin
      sram_addr = '0;
      protect   = 1'b0;

      if (!bus.mreq_n) begin
         unique case (bus.a[15:14])
            // -------------------------------------------------------------------
            // 0000-3fff, rom / divmmc / allram
            // -------------------------------------------------------------------
            2'b00: begin
               if (divmmc.active) begin
                  sram_addr.v8.off13 = bus.a[12:0];
                  if (!bus.a[13]) begin            // 0000-1fff
                     if (divmmc.mapram && !divmmc.conmem)
                        sram_addr.v8.page8 = DIVMMC_MAPRAM_PAGE8;
                     else
                        sram_addr.v8.page8 = DIVMMC_ROM_PAGE8;
                     protect = 1'b1;               // never writable here
                  end
                  else begin                       // 2000-3fff, divmmc ram
                     sram_addr.v8.page8 = DIVMMC_RAM_BASE8 + {2'b00, divmmc.page};
                     protect = divmmc.mapram && !divmmc.conmem &&
                               (divmmc.page == 4'd3);  // page 3 stands in for rom
                  end
               end
               else if (!paging.allram) begin
                  sram_addr.v16.page16 = ROM_PAGE_BASE + {3'b000, paging.rom_sel};
                  sram_addr.v16.off14  = bus.a[13:0];
                  protect = 1'b1;
               end
               else begin
                  sram_addr.v16.page16 = (paging.arrangement == 2'd0) ? 5'd0 : 5'd4;
                  sram_addr.v16.off14  = bus.a[13:0];
               end
            end

            // 4000-7fff
            2'b01: begin
               sram_addr.v16.off14 = bus.a[13:0];
               if (!paging.allram)
                  sram_addr.v16.page16 = SCREEN_PAGE;
               else begin
                  unique case (paging.arrangement)
                     2'd0:       sram_addr.v16.page16 = 5'd1;
                     2'd1, 2'd2: sram_addr.v16.page16 = 5'd5;
                     2'd3:       sram_addr.v16.page16 = 5'd7;
                  endcase
               end
            end

            // 8000-bfff
            2'b10: begin
               sram_addr.v16.off14  = bus.a[13:0];
               sram_addr.v16.page16 = (paging.allram && paging.arrangement != 2'd0) ?
                                      5'd6 : 5'd2;
            end

            // c000-ffff, 7ffd bank unless allram
            2'b11: begin
               sram_addr.v16.off14 = bus.a[13:0];
               if (!paging.allram)
                  sram_addr.v16.page16 = {2'b00, paging.ram_bank};
               else
                  sram_addr.v16.page16 = (paging.arrangement == 2'd1) ? 5'd7 : 5'd3;
            end
         endcase
      end
   end

   assign sram_we_n = bus.mreq_n | bus.wr_n | protect;

   // sampled when a new request arrives, so it checks the settled previous one;
   // no page of the whole map lands in the rom pages without protection
   a_rom_protect : assert property (
      @(bus)
      (sram_addr.v16.page16 inside {[ROM_PAGE_BASE : ROM_PAGE_BASE + 5'd3]}) |-> sram_we_n
   ) else $error("write strobe active in rom page %0d", sram_addr.v16.page16);

endmodule

//--- logic/divmmc_mapper.sv
`timescale 1ns/10ps

module divmmc_mapper
   import zxmem_pkg::*;
#(
   parameter logic [7:0] DIVMMC_PORT = 8'hE3
)(
   input  logic     clk,
   input  logic     mrst_n,
   input  cpu_bus_t bus,
   output divmmc_t  divmmc
);

   // -------------------------------------------------------------------------
   // control register, port DIVMMC_PORT
   // -------------------------------------------------------------------------
   logic       ctrl_wr;
   logic       conmem_q;    // bit 7, force mapping
   logic       mapram_q;    // bit 6, ram page 3 acts as rom
   logic [3:0] page_q;      // bits 3..0

   assign ctrl_wr = !bus.iorq_n && !bus.wr_n && (bus.a[7:0] == DIVMMC_PORT);

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         conmem_q <= 1'b0;
         mapram_q <= 1'b0;
         page_q   <= 4'd0;
      end
      else if (ctrl_wr) begin
         conmem_q <= bus.din[7];
         mapram_q <= bus.din[6];
         page_q   <= bus.din[3:0];
      end
   end

   // -------------------------------------------------------------------------
   // automapper
   // -------------------------------------------------------------------------
   logic fetch;        // m1 opcode read
   logic defer_hit;    // entry point, maps after m1
   logic now_hit;      // 3dxx, maps at once
   logic off_hit;      // 1ff8-1fff, unmaps after m1
   logic pending_q;    // state to take when m1 ends
   logic paged_q;

   assign fetch     = !bus.mreq_n && !bus.rd_n && !bus.m1_n;
   assign defer_hit = fetch && (bus.a inside {AUTOMAP_DEFERRED_0, AUTOMAP_DEFERRED_1,
                                              AUTOMAP_DEFERRED_2, AUTOMAP_DEFERRED_3,
                                              AUTOMAP_DEFERRED_4, AUTOMAP_DEFERRED_5});
   assign now_hit   = fetch && (bus.a[15:8] == AUTOMAP_NOW_HI);
   assign off_hit   = fetch && (bus.a[15:3] == AUTOMAP_OFF_BASE[15:3]);

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         pending_q <= 1'b0;
         paged_q   <= 1'b0;
      end
      else begin
         if (defer_hit) begin
            pending_q <= 1'b1;
         end
         else if (now_hit) begin
            pending_q <= 1'b1;
            paged_q   <= 1'b1;               // visible in the next access already
         end
         else if (off_hit) begin
            pending_q <= 1'b0;
         end
         if (bus.m1_n) begin
            paged_q <= pending_q;            // m1 is over, commit
         end
      end
   end

   assign divmmc.active = paged_q || conmem_q;
   assign divmmc.conmem = conmem_q;
   assign divmmc.mapram = mapram_q;
   assign divmmc.page   = page_q;

   // paging in during a fetch only happens for the 3dxx range
   a_paged_rise : assert property (
      @(posedge clk) disable iff (!mrst_n)
      (!paged_q && !bus.m1_n && !now_hit) |=> !paged_q
   ) else $error("divmmc paged in during m1 outside 3dxx");

endmodule

//--- logic/paging_regs.sv
`timescale 1ns/10ps

module paging_regs
   import zxmem_pkg::*;
(
   input  logic     clk,
   input  logic     mrst_n,
   input  cpu_bus_t bus,
   output paging_t  paging
);

   // -------------------------------------------------------------------------
   // port decode, +2A style
   // -------------------------------------------------------------------------
   logic io_wr;        // io write cycle in progress
   logic sel_7ffd;
   logic sel_1ffd;

   assign io_wr    = !bus.iorq_n && !bus.wr_n;
   assign sel_7ffd = bus.a[0] && !bus.a[1] && (bus.a[15:14] == 2'b01);
   assign sel_1ffd = bus.a[0] && !bus.a[1] && (bus.a[15:12] == 4'b0001);

   // only the bits the mapper uses are kept
   logic [2:0] ram_bank_q;   // 7ffd[2:0]
   logic       rom_lo_q;     // 7ffd[4]
   logic       locked_q;     // 7ffd[5]
   logic [2:0] p1ffd_q;      // 1ffd[2:0]

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         ram_bank_q <= 3'd0;
         rom_lo_q   <= 1'b0;
         locked_q   <= 1'b0;
         p1ffd_q    <= 3'd0;
      end
      else if (io_wr && !locked_q) begin     // lock freezes both ports
         if (sel_1ffd) begin
            p1ffd_q <= bus.din[2:0];
         end
         else if (sel_7ffd) begin
            ram_bank_q <= bus.din[2:0];
            rom_lo_q   <= bus.din[4];
            locked_q   <= bus.din[5];         // once set, only reset clears it
         end
      end
   end

   // -------------------------------------------------------------------------
   // field extraction
   // -------------------------------------------------------------------------
   assign paging.ram_bank    = ram_bank_q;
   assign paging.rom_sel     = {p1ffd_q[2], rom_lo_q};  // 1ffd bit above 7ffd bit
   assign paging.allram      = p1ffd_q[0];
   assign paging.arrangement = p1ffd_q[2:1];
   assign paging.locked      = locked_q;

   // a write seen while locked leaves every paging field as it was
   a_locked_stable : assert property (
      @(posedge clk) disable iff (!mrst_n)
      locked_q |=> $stable({ram_bank_q, rom_lo_q, locked_q, p1ffd_q})
   ) else $error("paging register changed while locked");

endmodule

//--- logic/zxmem_pkg.sv
package zxmem_pkg;

   // -------------------------------------------------------------------------
   // cpu side
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic [15:0] a;           // address bus
      logic [7:0]  din;         // data from cpu
      logic        mreq_n;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
      logic        m1_n;        // opcode fetch
   } cpu_bus_t;                 // 29 bits

   // decoded 128K/+3 paging state
   typedef struct packed {
      logic [2:0] ram_bank;     // 7ffd[2:0], page at c000
      logic [1:0] rom_sel;      // {1ffd[2], 7ffd[4]}
      logic       allram;       // 1ffd[0], special paging on
      logic [1:0] arrangement;  // 1ffd[2:1]
      logic       locked;       // 7ffd[5], ports frozen until reset
   } paging_t;                  // 9 bits

   // divmmc state as seen by the address mux
   typedef struct packed {
      logic       active;       // automapped or conmem
      logic       conmem;
      logic       mapram;
      logic [3:0] page;         // 8K ram page at 2000-3fff
   } divmmc_t;                  // 7 bits

   // -------------------------------------------------------------------------
   // sram address, same 19 bits seen as 16K or 8K pages
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic [4:0]  page16;
      logic [13:0] off14;
   } sram_addr16_t;

   typedef struct packed {
      logic [5:0]  page8;
      logic [12:0] off13;
   } sram_addr8_t;

   typedef union packed {
      sram_addr16_t v16;        // ram banks, 128K roms
      sram_addr8_t  v8;         // divmmc rom/ram
   } sram_addr_u;

   // page numbers
   localparam logic [5:0] DIVMMC_ROM_PAGE8    = 6'd24;  // esxdos rom
   localparam logic [5:0] DIVMMC_MAPRAM_PAGE8 = 6'd35;  // divmmc ram page 3
   localparam logic [5:0] DIVMMC_RAM_BASE8    = 6'd32;  // divmmc ram page 0
   localparam logic [4:0] SCREEN_PAGE         = 5'd5;

   // deferred automap entry points
   localparam logic [15:0] AUTOMAP_DEFERRED_0 = 16'h0000;
   localparam logic [15:0] AUTOMAP_DEFERRED_1 = 16'h0008;
   localparam logic [15:0] AUTOMAP_DEFERRED_2 = 16'h0038;
   localparam logic [15:0] AUTOMAP_DEFERRED_3 = 16'h0066;
   localparam logic [15:0] AUTOMAP_DEFERRED_4 = 16'h04C6;
   localparam logic [15:0] AUTOMAP_DEFERRED_5 = 16'h0562;

   localparam logic [7:0]  AUTOMAP_NOW_HI   = 8'h3D;     // 3dxx, maps during fetch
   localparam logic [15:0] AUTOMAP_OFF_BASE = 16'h1FF8;  // 1ff8-1fff unmaps

endpackage
